// File: src/lc3b_types.sv
`default_nettype none

package lc3b_types;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;
	typedef logic [2:0]  lc3b_nzp;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_and  = 4'd1,
		alu_not  = 4'd2,
		alu_pass = 4'd3,
		alu_sll  = 4'd4,
		alu_srl  = 4'd5,
		alu_sra  = 4'd6
	} lc3b_aluop;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_aluop  aluop;
		logic       sr1_needed;
		logic       sr2_needed;
		// 0 picks ir[11:9], 1 picks ir[2:0].
		logic       regfilemux_sel;
		// 0 picks ir[11:9], 1 picks R7.
		logic       destmux_sel;
		logic       ld_reg;
		logic       ld_cc;
		logic       mem_read;
		logic       mem_write;
		logic       branch_stall;
	} lc3b_control_word;

	typedef struct packed {
		lc3b_word npc;
		lc3b_word ir;
	} fetch_pkt_t;

	typedef struct packed {
		lc3b_word         npc;
		lc3b_control_word cw;
		lc3b_word         ir;
		lc3b_word         sr1_data;
		lc3b_word         sr2_data;
		lc3b_nzp          cc;
		lc3b_reg          dr;
		lc3b_reg          sr1_reg;
		lc3b_reg          sr2_reg;
	} decode_pkt_t;

	typedef struct packed {
		logic    ld_reg;
		logic    ld_cc;
		lc3b_reg drid;
	} stage_dst_t;

	typedef struct packed {
		logic     ld_reg;
		logic     ld_cc;
		lc3b_reg  dest;
		lc3b_word reg_data;
		lc3b_nzp  cc_data;
	} wb_write_t;

	typedef struct packed {
		logic execute_br;
		logic execute_indirect;
		logic mem;
		logic mem_br;
		logic icache;
	} stall_in_t;

endpackage : lc3b_types

`default_nettype wire

// File: src/pipe_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage_reg
#(
	parameter type payload_t = logic [15:0]
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     load,
	input  payload_t d,
	input  logic     d_valid,
	output payload_t q,
	output logic     q_valid
);

	// Reset clears only the valid bit.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			q_valid <= 1'b0;
		end
		else if (load)
		begin
			q_valid <= d_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			q <= d;
		end
	end

endmodule : pipe_stage_reg

`default_nettype wire

// File: src/control_rom.sv
`timescale 1ns/1ps
`default_nettype none

module control_rom import lc3b_types::*;
(
	input  lc3b_word         ir,
	output lc3b_control_word cw
);

	lc3b_opcode opcode;

	assign opcode = lc3b_opcode'(ir[15:12]);

	always_comb
	begin
		cw = '0;
		cw.opcode = opcode;
		cw.aluop = alu_add;

		case (opcode)
			op_add, op_and:
			begin
				cw.aluop = (opcode == op_add) ? alu_add : alu_and;
				cw.sr1_needed = 1'b1;
				// Bit 5 selects imm5, otherwise SR2 comes from ir[2:0].
				cw.sr2_needed = ~ir[5];
				cw.regfilemux_sel = 1'b1;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
			end
			op_not:
			begin
				cw.aluop = alu_not;
				cw.sr1_needed = 1'b1;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
			end
			op_shf:
			begin
				if (!ir[4])
					cw.aluop = alu_sll;
				else if (ir[5])
					cw.aluop = alu_sra;
				else
					cw.aluop = alu_srl;
				cw.sr1_needed = 1'b1;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
			end
			op_ldr, op_ldb, op_ldi:
			begin
				cw.sr1_needed = 1'b1;
				cw.ld_reg = 1'b1;
				cw.ld_cc = 1'b1;
				cw.mem_read = 1'b1;
			end
			op_str, op_stb, op_sti:
			begin
				// The stored register is named by ir[11:9].
				cw.sr1_needed = 1'b1;
				cw.sr2_needed = 1'b1;
				cw.regfilemux_sel = 1'b0;
				cw.mem_write = 1'b1;
				cw.mem_read = (opcode == op_sti);
			end
			op_lea:
			begin
				cw.ld_reg = 1'b1;
			end
			op_br:
			begin
				cw.aluop = alu_pass;
				cw.branch_stall = 1'b1;
			end
			op_jmp:
			begin
				cw.aluop = alu_pass;
				cw.sr1_needed = 1'b1;
				cw.branch_stall = 1'b1;
			end
			op_jsr:
			begin
				// JSRR takes its target from BaseR, JSR is PC-relative.
				cw.sr1_needed = ~ir[11];
				cw.destmux_sel = 1'b1;
				cw.ld_reg = 1'b1;
				cw.branch_stall = 1'b1;
			end
			op_trap:
			begin
				cw.destmux_sel = 1'b1;
				cw.ld_reg = 1'b1;
				cw.mem_read = 1'b1;
				cw.branch_stall = 1'b1;
			end
			default:
			begin
				cw.aluop = alu_pass;
			end
		endcase

		// An all-zero word is the pipeline NOP.
		if (ir == 16'h0000)
			cw = '0;
	end

endmodule : control_rom

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import lc3b_types::*;
(
	input  logic     clk,
	input  logic     load,
	input  lc3b_word in,
	input  lc3b_reg  src_a,
	input  lc3b_reg  src_b,
	input  lc3b_reg  dest,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

	lc3b_word data [8];

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			data[dest] <= in;
		end
	end

	// A read in the same cycle as a write returns the old value.
	assign reg_a = data[src_a];
	assign reg_b = data[src_b];

endmodule : regfile

`default_nettype wire

// File: src/dep_check.sv
`timescale 1ns/1ps
`default_nettype none

module dep_check import lc3b_types::*;
(
	input  lc3b_reg          sr1,
	input  lc3b_reg          sr2,
	input  lc3b_control_word cw,
	input  logic             valid,
	input  stage_dst_t       ex_dst,
	input  stage_dst_t       mem_dst,
	input  stage_dst_t       wb_dst,
	output logic             dep_stall
);

	logic sr1_hit;
	logic sr2_hit;
	logic cc_hit;
	logic is_br;

	function automatic logic reg_match(lc3b_reg src, stage_dst_t dst);
		return dst.ld_reg && (dst.drid == src);
	endfunction

	assign sr1_hit = cw.sr1_needed &&
			(reg_match(sr1, ex_dst) || reg_match(sr1, mem_dst) || reg_match(sr1, wb_dst));

	assign sr2_hit = cw.sr2_needed &&
			(reg_match(sr2, ex_dst) || reg_match(sr2, mem_dst) || reg_match(sr2, wb_dst));

	// The NOP shares opcode 0000 with BR, but it has no branch_stall bit.
	assign is_br = cw.branch_stall && (cw.opcode == op_br);

	assign cc_hit = is_br && (ex_dst.ld_cc || mem_dst.ld_cc || wb_dst.ld_cc);

	assign dep_stall = valid && (sr1_hit || sr2_hit || cc_hit);

endmodule : dep_check

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage import lc3b_types::*;
(
	input  logic        clk,
	input  logic        rst,
	input  fetch_pkt_t  pkt_in,
	input  logic        valid_in,
	input  wb_write_t   wb,
	input  stage_dst_t  ex_dst,
	input  stage_dst_t  mem_dst,
	input  stage_dst_t  wb_dst,
	input  stall_in_t   stalls,
	output decode_pkt_t pkt_out,
	output logic        valid_out,
	output logic        load_if,
	output logic        load_ex,
	output logic        dep_stall,
	output logic        decode_br_stall
);

	lc3b_control_word cw;
	lc3b_reg          sr1_reg;
	lc3b_reg          sr2_reg;
	lc3b_reg          dr;
	lc3b_word         sr1_data;
	lc3b_word         sr2_data;
	lc3b_nzp          cc_q;
	logic             reg_we;
	logic             cc_we;
	logic             downstream_stall;

	control_rom u_control_rom
	(
		.ir(pkt_in.ir),
		.cw(cw)
	);

	assign sr1_reg = pkt_in.ir[8:6];
	assign sr2_reg = cw.regfilemux_sel ? pkt_in.ir[2:0] : pkt_in.ir[11:9];
	assign dr = cw.destmux_sel ? 3'b111 : pkt_in.ir[11:9];

	// Writeback carries no valid data during reset, so its writes are dropped.
	assign reg_we = wb.ld_reg && !rst;
	assign cc_we = wb.ld_cc && !rst;

	regfile u_regfile
	(
		.clk(clk),
		.load(reg_we),
		.in(wb.reg_data),
		.src_a(sr1_reg),
		.src_b(sr2_reg),
		.dest(wb.dest),
		.reg_a(sr1_data),
		.reg_b(sr2_data)
	);

	always_ff @(posedge clk)
	begin
		if (cc_we)
		begin
			cc_q <= wb.cc_data;
		end
	end

	dep_check u_dep_check
	(
		.sr1(sr1_reg),
		.sr2(sr2_reg),
		.cw(cw),
		.valid(valid_in),
		.ex_dst(ex_dst),
		.mem_dst(mem_dst),
		.wb_dst(wb_dst),
		.dep_stall(dep_stall)
	);

	always_comb
	begin
		pkt_out.npc = pkt_in.npc;
		pkt_out.cw = cw;
		pkt_out.ir = pkt_in.ir;
		pkt_out.sr1_data = sr1_data;
		pkt_out.sr2_data = sr2_data;
		pkt_out.cc = cc_q;
		pkt_out.dr = dr;
		pkt_out.sr1_reg = sr1_reg;
		pkt_out.sr2_reg = sr2_reg;
	end

	assign downstream_stall = |stalls;
	assign load_ex = ~downstream_stall;

	// A dependency holds the instruction in if_id and sends a bubble onward.
	assign valid_out = valid_in && !dep_stall;
	assign load_if = load_ex && !dep_stall;

	assign decode_br_stall = valid_in && cw.branch_stall;

endmodule : decode_stage

`default_nettype wire

// File: src/decode_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module decode_subsystem import lc3b_types::*;
(
	input  logic        clk,
	input  logic        rst,
	input  fetch_pkt_t  fetch_in,
	input  logic        fetch_valid,
	input  stage_dst_t  ex_dst,
	input  stage_dst_t  mem_dst,
	input  stage_dst_t  wb_dst,
	input  wb_write_t   wb,
	input  stall_in_t   stalls,
	output decode_pkt_t id_ex,
	output logic        id_ex_valid,
	output logic        fetch_hold,
	output logic        decode_br_stall,
	output logic        dep_stall
);

	fetch_pkt_t  if_id_pkt;
	logic        if_id_valid;
	decode_pkt_t dec_pkt;
	logic        dec_valid;
	logic        load_if;
	logic        load_ex;

	pipe_stage_reg #(.payload_t(fetch_pkt_t)) if_id
	(
		.clk(clk),
		.rst(rst),
		.load(load_if),
		.d(fetch_in),
		.d_valid(fetch_valid),
		.q(if_id_pkt),
		.q_valid(if_id_valid)
	);

	decode_stage u_decode_stage
	(
		.clk(clk),
		.rst(rst),
		.pkt_in(if_id_pkt),
		.valid_in(if_id_valid),
		.wb(wb),
		.ex_dst(ex_dst),
		.mem_dst(mem_dst),
		.wb_dst(wb_dst),
		.stalls(stalls),
		.pkt_out(dec_pkt),
		.valid_out(dec_valid),
		.load_if(load_if),
		.load_ex(load_ex),
		.dep_stall(dep_stall),
		.decode_br_stall(decode_br_stall)
	);

	pipe_stage_reg #(.payload_t(decode_pkt_t)) id_ex_reg
	(
		.clk(clk),
		.rst(rst),
		.load(load_ex),
		.d(dec_pkt),
		.d_valid(dec_valid),
		.q(id_ex),
		.q_valid(id_ex_valid)
	);

	assign fetch_hold = ~load_if;

endmodule : decode_subsystem

`default_nettype wire

// File: verification/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen
(
	output logic clk
);

	// Half of the 20 ns period.
	localparam int half_period = 10;

	initial
	begin
		clk = 1'b0;
		forever
			#half_period clk = ~clk;
	end

endmodule : clk_gen

`default_nettype wire

// File: verification/decode_props.sv
`timescale 1ns/1ps
`default_nettype none

module decode_props import lc3b_types::*;
(
	input logic        clk,
	input logic        rst,
	input stall_in_t   stalls,
	input decode_pkt_t id_ex,
	input logic        id_ex_valid,
	input logic        fetch_hold,
	input logic        dep_stall
);

	int assert_failures = 0;

	a_reset_clears_valid: assert property (@(posedge clk) rst |=> !id_ex_valid)
	else
	begin
		assert_failures++;
		$error("id_ex_valid high in the cycle after reset");
	end

	a_hold_rule: assert property (@(posedge clk) disable iff (rst)
			fetch_hold == (dep_stall || (|stalls)))
	else
	begin
		assert_failures++;
		$error("fetch_hold differs from dep_stall or downstream stall");
	end

	// The output latch must not move while any downstream stage stalls.
	a_id_ex_holds: assert property (@(posedge clk) disable iff (rst)
			(|stalls) |=> ($stable(id_ex) && $stable(id_ex_valid)))
	else
	begin
		assert_failures++;
		$error("id_ex changed during a downstream stall");
	end

endmodule : decode_props

bind decode_subsystem decode_props u_props (.*);

`default_nettype wire

// File: verification/tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode import lc3b_types::*;
();

	// About 80 cycles of tests plus 10 of reset, with ample margin.
	localparam int max_cycles = 400;

	logic        clk;
	logic        rst;
	fetch_pkt_t  fetch_in;
	logic        fetch_valid;
	stage_dst_t  ex_dst;
	stage_dst_t  mem_dst;
	stage_dst_t  wb_dst;
	wb_write_t   wb;
	stall_in_t   stalls;
	decode_pkt_t id_ex;
	logic        id_ex_valid;
	logic        fetch_hold;
	logic        decode_br_stall;
	logic        dep_stall;

	lc3b_word rf_model [8];
	lc3b_nzp  cc_model;
	lc3b_word pc = 16'h3000;
	int       errors = 0;
	int       tests = 0;
	int       cycles = 0;
	int       seed = 84474;

	clk_gen u_clk_gen
	(
		.clk(clk)
	);

	decode_subsystem UUT
	(
		.clk(clk),
		.rst(rst),
		.fetch_in(fetch_in),
		.fetch_valid(fetch_valid),
		.ex_dst(ex_dst),
		.mem_dst(mem_dst),
		.wb_dst(wb_dst),
		.wb(wb),
		.stalls(stalls),
		.id_ex(id_ex),
		.id_ex_valid(id_ex_valid),
		.fetch_hold(fetch_hold),
		.decode_br_stall(decode_br_stall),
		.dep_stall(dep_stall)
	);

	// Reference control store, written from the LC-3b decode rules.
	function automatic lc3b_control_word ref_cw(input lc3b_word ir);
		lc3b_control_word c;
		lc3b_opcode op;
		op = lc3b_opcode'(ir[15:12]);
		c = '0;
		c.opcode = op;
		c.aluop = alu_add;
		case (op)
			op_add, op_and:
			begin
				c.aluop = (op == op_and) ? alu_and : alu_add;
				c.sr1_needed = 1'b1;
				c.sr2_needed = !ir[5];
				c.regfilemux_sel = 1'b1;
				c.ld_reg = 1'b1;
				c.ld_cc = 1'b1;
			end
			op_not, op_shf, op_ldb, op_ldr, op_ldi:
			begin
				c.sr1_needed = 1'b1;
				c.ld_reg = 1'b1;
				c.ld_cc = 1'b1;
				c.mem_read = (op == op_ldb) || (op == op_ldr) || (op == op_ldi);
				if (op == op_not)
					c.aluop = alu_not;
				else if (op == op_shf)
					c.aluop = !ir[4] ? alu_sll : (ir[5] ? alu_sra : alu_srl);
			end
			op_stb, op_str, op_sti:
			begin
				c.sr1_needed = 1'b1;
				c.sr2_needed = 1'b1;
				c.mem_write = 1'b1;
				c.mem_read = (op == op_sti);
			end
			op_lea: c.ld_reg = 1'b1;
			op_br, op_jmp:
			begin
				c.aluop = alu_pass;
				c.sr1_needed = (op == op_jmp);
				c.branch_stall = 1'b1;
			end
			op_jsr, op_trap:
			begin
				c.sr1_needed = (op == op_jsr) && !ir[11];
				c.mem_read = (op == op_trap);
				c.destmux_sel = 1'b1;
				c.ld_reg = 1'b1;
				c.branch_stall = 1'b1;
			end
			default: c.aluop = alu_pass;
		endcase
		if (ir == 16'h0000)
			c = '0;
		return c;
	endfunction

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		errors++;
		$display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic end_test(input string name, input int start);
		tests++;
		$display("%0t %s finished with %0d mismatches", $time, name, errors - start);
	endtask

	task automatic next_cycle;
		@(posedge clk);
		#2;
	endtask

	task automatic write_reg(input lc3b_reg r, input lc3b_word v);
		wb.ld_reg = 1'b1;
		wb.dest = r;
		wb.reg_data = v;
		next_cycle();
		wb.ld_reg = 1'b0;
		rf_model[r] = v;
	endtask

	task automatic write_cc(input lc3b_nzp v);
		wb.ld_cc = 1'b1;
		wb.cc_data = v;
		next_cycle();
		wb.ld_cc = 1'b0;
		cc_model = v;
	endtask

	// Puts one instruction into if_id, so that it sits in decode on return.
	task automatic issue(input lc3b_word ir);
		pc = pc + 16'd2;
		fetch_in.npc = pc;
		fetch_in.ir = ir;
		fetch_valid = 1'b1;
		next_cycle();
		fetch_valid = 1'b0;
	endtask

	task automatic wait_id_ex_valid;
		int n;
		n = 0;
		while (id_ex_valid !== 1'b1 && n < 8)
		begin
			next_cycle();
			n++;
		end
		if (id_ex_valid !== 1'b1)
		begin
			errors++;
			$display("At %0t id_ex_valid did not rise within 8 cycles", $time);
		end
	endtask

	task automatic check_id_ex(input lc3b_word ir);
		lc3b_control_word c;
		lc3b_reg s1;
		lc3b_reg s2;
		lc3b_reg d;
		c = ref_cw(ir);
		s1 = ir[8:6];
		s2 = c.regfilemux_sel ? ir[2:0] : ir[11:9];
		d = c.destmux_sel ? 3'd7 : ir[11:9];
		if (id_ex_valid !== 1'b1)
			report_mismatch("id_ex_valid", id_ex_valid, 1'b1);
		if (id_ex.npc !== pc)
			report_mismatch("id_ex.npc", id_ex.npc, pc);
		if (id_ex.ir !== ir)
			report_mismatch("id_ex.ir", id_ex.ir, ir);
		if (id_ex.cw !== c)
			report_mismatch("id_ex.cw", id_ex.cw, c);
		if (id_ex.dr !== d)
			report_mismatch("id_ex.dr", id_ex.dr, d);
		if (id_ex.sr1_reg !== s1)
			report_mismatch("id_ex.sr1_reg", id_ex.sr1_reg, s1);
		if (id_ex.sr2_reg !== s2)
			report_mismatch("id_ex.sr2_reg", id_ex.sr2_reg, s2);
		if (id_ex.sr1_data !== rf_model[s1])
			report_mismatch("id_ex.sr1_data", id_ex.sr1_data, rf_model[s1]);
		if (id_ex.sr2_data !== rf_model[s2])
			report_mismatch("id_ex.sr2_data", id_ex.sr2_data, rf_model[s2]);
		if (id_ex.cc !== cc_model)
			report_mismatch("id_ex.cc", id_ex.cc, cc_model);
	endtask

	task automatic read_all_registers;
		int start;
		int r;
		lc3b_word ir;
		start = errors;
		for (r = 0; r < 8; r++)
			write_reg(r[2:0], lc3b_word'($urandom));
		write_cc(3'b010);
		ir = {4'b0001, 3'd3, 3'd5, 3'b000, 3'd6};
		issue(ir);
		next_cycle();
		check_id_ex(ir);
		end_test("register_read", start);
	endtask

	task automatic select_fields;
		int start;
		lc3b_word ir;
		start = errors;
		ir = {4'b0001, 3'd2, 3'd1, 1'b1, 5'h05};
		issue(ir);
		next_cycle();
		check_id_ex(ir);
		if (id_ex.cw.sr2_needed !== 1'b0)
			report_mismatch("id_ex.cw.sr2_needed", id_ex.cw.sr2_needed, 1'b0);
		// STR takes its stored register from ir[11:9].
		ir = {4'b0111, 3'd3, 3'd4, 6'h02};
		issue(ir);
		next_cycle();
		check_id_ex(ir);
		if (id_ex.cw.sr2_needed !== 1'b1)
			report_mismatch("id_ex.cw.sr2_needed", id_ex.cw.sr2_needed, 1'b1);
		if (id_ex.sr2_reg !== 3'd3)
			report_mismatch("id_ex.sr2_reg", id_ex.sr2_reg, 3'd3);
		ir = {4'b0100, 1'b1, 11'h020};
		issue(ir);
		next_cycle();
		check_id_ex(ir);
		if (id_ex.dr !== 3'd7)
			report_mismatch("id_ex.dr", id_ex.dr, 3'd7);
		issue(16'h0000);
		next_cycle();
		check_id_ex(16'h0000);
		if (id_ex.cw !== '0)
			report_mismatch("id_ex.cw", id_ex.cw, 0);
		end_test("field_select", start);
	endtask

	task automatic stall_on_dependency;
		int start;
		int s;
		stage_dst_t pend;
		lc3b_word ir;
		start = errors;
		for (s = 0; s < 4; s++)
		begin
			// Fields are ld_reg, ld_cc and drid; the last pass is BR against ld_cc.
			pend = (s < 3) ? {1'b1, 1'b0, 3'd5} : {1'b0, 1'b1, 3'd0};
			ir = (s < 3) ? {4'b0001, 3'd1, 3'd5, 3'b000, 3'd2} : {4'b0000, 3'b111, 9'h010};
			if (s == 1)
				mem_dst = pend;
			else if (s == 2)
				wb_dst = pend;
			else
				ex_dst = pend;
			issue(ir);
			if (dep_stall !== 1'b1)
				report_mismatch("dep_stall", dep_stall, 1'b1);
			if (fetch_hold !== 1'b1)
				report_mismatch("fetch_hold", fetch_hold, 1'b1);
			next_cycle();
			if (id_ex_valid !== 1'b0)
				report_mismatch("id_ex_valid", id_ex_valid, 1'b0);
			ex_dst = '0;
			mem_dst = '0;
			wb_dst = '0;
			wait_id_ex_valid();
			check_id_ex(ir);
		end
		end_test("dep_stall", start);
	endtask

	task automatic stall_on_branch;
		int start;
		int i;
		lc3b_word irs [4];
		start = errors;
		irs[0] = {4'b0000, 3'b010, 9'h004};
		irs[1] = {4'b1100, 3'b000, 3'd2, 6'h00};
		irs[2] = {4'b1111, 4'h0, 8'h25};
		irs[3] = {4'b0001, 3'd1, 3'd1, 1'b1, 5'd1};
		for (i = 0; i < 4; i++)
		begin
			issue(irs[i]);
			if (decode_br_stall !== (i < 3))
				report_mismatch("decode_br_stall", decode_br_stall, i < 3);
			next_cycle();
			check_id_ex(irs[i]);
		end
		end_test("branch_stall", start);
	endtask

	task automatic hold_under_backpressure;
		int start;
		int b;
		int k;
		lc3b_word ir_a;
		lc3b_word ir_b;
		decode_pkt_t held;
		start = errors;
		for (b = 0; b < 5; b++)
		begin
			ir_a = {4'b0001, b[2:0], 3'd2, 1'b1, 2'b00, b[2:0]};
			ir_b = {4'b0101, 3'd4, b[2:0], 1'b1, 5'h1f};
			issue(ir_a);
			next_cycle();
			check_id_ex(ir_a);
			held = id_ex;
			pc = pc + 16'd2;
			fetch_in.npc = pc;
			fetch_in.ir = ir_b;
			fetch_valid = 1'b1;
			stalls = stall_in_t'(5'b00001 << b);
			for (k = 0; k < 3; k++)
			begin
				next_cycle();
				if (id_ex !== held)
					report_mismatch("id_ex", id_ex, held);
				if (id_ex_valid !== 1'b1)
					report_mismatch("id_ex_valid", id_ex_valid, 1'b1);
				if (fetch_hold !== 1'b1)
					report_mismatch("fetch_hold", fetch_hold, 1'b1);
			end
			stalls = '0;
			next_cycle();
			fetch_valid = 1'b0;
			wait_id_ex_valid();
			check_id_ex(ir_b);
		end
		end_test("backpressure", start);
	endtask

	task automatic pass_cc_to_id_ex;
		int start;
		lc3b_word ir;
		start = errors;
		ir = {4'b0001, 3'd0, 3'd1, 3'b000, 3'd2};
		write_cc(3'b100);
		issue(ir);
		next_cycle();
		check_id_ex(ir);
		if (id_ex.cc !== 3'b100)
			report_mismatch("id_ex.cc", id_ex.cc, 3'b100);
		write_cc(3'b001);
		issue(ir);
		next_cycle();
		check_id_ex(ir);
		if (id_ex.cc !== 3'b001)
			report_mismatch("id_ex.cc", id_ex.cc, 3'b001);
		end_test("cc_path", start);
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("Timeout after %0d cycles", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial
	begin
		rst = 1'b1;
		fetch_in = '0;
		fetch_valid = 1'b0;
		ex_dst = '0;
		mem_dst = '0;
		wb_dst = '0;
		wb = '0;
		stalls = '0;
		void'($urandom(seed));
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;
		read_all_registers();
		select_fields();
		stall_on_dependency();
		stall_on_branch();
		hold_under_backpressure();
		pass_cc_to_id_ex();
		next_cycle();
		$display("%0d tests, %0d mismatches, %0d assertion failures", tests, errors,
				UUT.u_props.assert_failures);
		if (errors == 0 && UUT.u_props.assert_failures == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule : tb_decode

`default_nettype wire

// File: filelist.f
src/lc3b_types.sv
src/pipe_stage_reg.sv
src/control_rom.sv
src/regfile.sv
src/dep_check.sv
src/decode_stage.sv
src/decode_subsystem.sv
verification/clk_gen.sv
verification/decode_props.sv
verification/tb_decode.sv
